/* rtl/dcachePkg.sv */
package dcachePkg;

   localparam int WORD_WIDTH = 32;
   localparam int TAG_WIDTH = 26;
   localparam int INDEX_WIDTH = 3;
   localparam int NUM_SETS = 8;

   typedef logic [WORD_WIDTH-1:0] word_t;
   typedef logic [TAG_WIDTH-1:0] tag_t;
   typedef logic [INDEX_WIDTH-1:0] index_t;

   // hit count lands here on halt
   localparam word_t HIT_COUNT_ADDR = 32'h3100;

   // address layout is tag, index, word offset, 2'b00
   typedef struct packed {
      logic valid;
      logic dirty;
      tag_t tag;
   } lineMeta_t;

   typedef struct packed {
      word_t high;
      word_t low;
   } lineData_t;

   // source of the memory address
   typedef enum logic [2:0] {
      selNone,
      selFill,     // request line
      selVictim,   // line being evicted
      selFlush,    // walker line
      selCount     // hit count word
   } memSel_t;

endpackage

/* rtl/setArray.sv */
`timescale 1ns/100ps

module setArray #(
   parameter type entryT = logic [7:0]
) (
   input logic CLK,
   input logic nRST,
   input logic writeEn,
   input dcachePkg::index_t writeIndex,
   input entryT writeEntry,
   input dcachePkg::index_t readIndexA,
   output entryT readEntryA,
   input dcachePkg::index_t readIndexB,
   output entryT readEntryB
);

   entryT entries [dcachePkg::NUM_SETS];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 0; i < dcachePkg::NUM_SETS; i++)
            entries[i] <= '0;
      end
      else if (writeEn)
         entries[writeIndex] <= writeEntry;
   end

   assign readEntryA = entries[readIndexA];   // request port
   assign readEntryB = entries[readIndexB];   // flush port

endmodule

/* rtl/wayLookup.sv */
`timescale 1ns/100ps

module wayLookup (
   input logic CLK,
   input logic nRST,
   input dcachePkg::tag_t reqTag,
   input dcachePkg::index_t reqIndex,
   input logic wordHigh,
   input dcachePkg::lineMeta_t meta0,
   input dcachePkg::lineMeta_t meta1,
   input dcachePkg::lineData_t data0,
   input dcachePkg::lineData_t data1,
   input logic lruUpdate,
   output logic hit,
   output logic hitWay,
   output logic victimWay,
   output dcachePkg::lineMeta_t victimMeta,
   output dcachePkg::lineData_t victimData,
   output dcachePkg::word_t loadWord
);

   logic [dcachePkg::NUM_SETS-1:0] lru;   // names the victim way per set
   logic match0;
   logic match1;
   dcachePkg::lineData_t hitLine;

   assign match0 = meta0.valid && (meta0.tag == reqTag);
   assign match1 = meta1.valid && (meta1.tag == reqTag);

   assign hit = match0 || match1;
   assign hitWay = match1;

   assign hitLine = hitWay ? data1 : data0;
   assign loadWord = wordHigh ? hitLine.high : hitLine.low;

   assign victimWay = lru[reqIndex];
   assign victimMeta = victimWay ? meta1 : meta0;
   assign victimData = victimWay ? data1 : data0;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         lru <= '0;
      else if (lruUpdate)
         lru[reqIndex] <= ~lru[reqIndex];   // away from the way just filled
   end

endmodule

/* rtl/memAccess.sv */
`timescale 1ns/100ps

module memAccess (
   input dcachePkg::memSel_t memSel,
   input logic wordHigh,
   input dcachePkg::tag_t reqTag,
   input dcachePkg::index_t reqIndex,
   input logic reqOffset,
   input dcachePkg::lineMeta_t victimMeta,
   input dcachePkg::lineData_t victimData,
   input dcachePkg::index_t flushIndex,
   input logic flushWay,
   input dcachePkg::lineMeta_t flushMeta0,
   input dcachePkg::lineMeta_t flushMeta1,
   input dcachePkg::lineData_t flushData0,
   input dcachePkg::lineData_t flushData1,
   input dcachePkg::word_t hitCount,
   input dcachePkg::word_t storeWord,
   input dcachePkg::word_t loadWord,
   input dcachePkg::word_t dload,
   input dcachePkg::lineData_t hitData,
   input logic captureFill,
   input logic mergeStore,
   input logic markDirty,
   output dcachePkg::word_t daddr,
   output dcachePkg::word_t dstore,
   output dcachePkg::lineMeta_t newMeta,
   output dcachePkg::lineData_t newData
);

   dcachePkg::lineMeta_t flushMeta;
   dcachePkg::lineData_t flushData;
   dcachePkg::word_t reqWord;
   dcachePkg::word_t fillWord;

   assign flushMeta = flushWay ? flushMeta1 : flushMeta0;
   assign flushData = flushWay ? flushData1 : flushData0;

   always_comb
   begin
      daddr = '0;
      dstore = '0;
      case (memSel)
         dcachePkg::selFill: daddr = {reqTag, reqIndex, wordHigh, 2'b00};
         dcachePkg::selVictim:
         begin
            daddr = {victimMeta.tag, reqIndex, wordHigh, 2'b00};   // old tag, same set
            dstore = wordHigh ? victimData.high : victimData.low;
         end
         dcachePkg::selFlush:
         begin
            daddr = {flushMeta.tag, flushIndex, wordHigh, 2'b00};
            dstore = wordHigh ? flushData.high : flushData.low;
         end
         dcachePkg::selCount:
         begin
            daddr = dcachePkg::HIT_COUNT_ADDR;
            dstore = hitCount;
         end
         default: ;
      endcase
   end

   assign newMeta = '{valid: 1'b1, dirty: markDirty, tag: reqTag};

   assign reqWord = mergeStore ? storeWord : loadWord;
   // store overrides the fetched word at its own offset
   assign fillWord = (mergeStore && (reqOffset == wordHigh)) ? storeWord : dload;

   always_comb
   begin
      if (captureFill)
      begin
         newData = victimData;   // holds the half already fetched
         if (wordHigh)
            newData.high = fillWord;
         else
            newData.low = fillWord;
      end
      else
      begin
         newData = hitData;
         if (reqOffset)
            newData.high = reqWord;
         else
            newData.low = reqWord;
      end
   end

endmodule

/* rtl/cacheController.sv */
`timescale 1ns/100ps

module cacheController (
   input logic CLK,
   input logic nRST,
   input logic dmemREN,
   input logic dmemWEN,
   input logic halt,
   input logic dwait,
   input logic hit,
   input logic hitWay,
   input logic victimWay,
   input logic victimDirty,
   input logic flushDirty,
   output logic dREN,
   output logic dWEN,
   output dcachePkg::memSel_t memSel,
   output logic wordHigh,
   output logic [1:0] metaWriteEn,
   output logic [1:0] dataWriteEn,
   output logic captureFill,
   output logic mergeStore,
   output logic markDirty,
   output logic lruUpdate,
   output dcachePkg::index_t flushIndex,
   output logic flushWay,
   output dcachePkg::word_t hitCount,
   output logic dhit,
   output logic flushed
);

   typedef enum logic [3:0] {
      idle,
      writeHit,
      wbLow,
      wbHigh,
      fillLow,
      fillHigh,
      install,
      respond,
      countWrite,
      flushLow,
      flushHigh,
      flushStep,
      done
   } state_t;

   state_t state;
   state_t nextState;
   logic [dcachePkg::INDEX_WIDTH:0] walkPos;   // set, then way in the lsb
   logic [dcachePkg::INDEX_WIDTH:0] nextWalkPos;
   logic walkLast;
   dcachePkg::word_t nextHitCount;

   assign {flushIndex, flushWay} = walkPos;
   assign walkLast = &walkPos;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= idle;
         walkPos <= '0;
         hitCount <= '0;
      end
      else
      begin
         state <= nextState;
         walkPos <= nextWalkPos;
         hitCount <= nextHitCount;
      end
   end

   always_comb
   begin
      nextState = state;
      nextWalkPos = walkPos;
      nextHitCount = hitCount;
      dREN = 1'b0;
      dWEN = 1'b0;
      memSel = dcachePkg::selNone;
      wordHigh = 1'b0;
      metaWriteEn = '0;
      dataWriteEn = '0;
      captureFill = 1'b0;
      mergeStore = 1'b0;
      markDirty = 1'b0;
      lruUpdate = 1'b0;
      dhit = 1'b0;
      flushed = 1'b0;

      case (state)
         idle:
         begin
            if (dmemREN || dmemWEN)
            begin
               if (hit)
               begin
                  nextHitCount = hitCount + 1;   // first lookup only
                  if (dmemWEN)
                     nextState = writeHit;
                  else
                     dhit = 1'b1;   // read hit, same cycle
               end
               else if (victimDirty)
                  nextState = wbLow;
               else
                  nextState = fillLow;
            end
            else if (halt)
               nextState = countWrite;
         end
         writeHit:
         begin
            dataWriteEn = 2'b01 << hitWay;
            metaWriteEn = 2'b01 << hitWay;
            mergeStore = 1'b1;
            markDirty = 1'b1;
            nextState = respond;
         end
         wbLow:
         begin
            dWEN = 1'b1;
            memSel = dcachePkg::selVictim;
            if (!dwait)
               nextState = wbHigh;
         end
         wbHigh:
         begin
            dWEN = 1'b1;
            memSel = dcachePkg::selVictim;
            wordHigh = 1'b1;
            if (!dwait)
               nextState = fillLow;
         end
         fillLow, fillHigh:
         begin
            dREN = 1'b1;
            memSel = dcachePkg::selFill;
            wordHigh = (state == fillHigh);
            captureFill = 1'b1;
            mergeStore = dmemWEN;   // write miss merges its word
            if (!dwait)
            begin
               dataWriteEn = 2'b01 << victimWay;
               nextState = (state == fillHigh) ? install : fillHigh;
            end
         end
         install:
         begin
            metaWriteEn = 2'b01 << victimWay;
            markDirty = dmemWEN;
            lruUpdate = 1'b1;
            nextState = respond;
         end
         respond:
         begin
            dhit = 1'b1;
            nextState = idle;
         end
         countWrite:
         begin
            dWEN = 1'b1;
            memSel = dcachePkg::selCount;
            if (!dwait)
               nextState = flushStep;
         end
         flushStep:
         begin
            if (flushDirty)
               nextState = flushLow;
            else if (walkLast)
               nextState = done;
            else
               nextWalkPos = walkPos + 1'b1;   // skip clean or invalid
         end
         flushLow:
         begin
            dWEN = 1'b1;
            memSel = dcachePkg::selFlush;
            if (!dwait)
               nextState = flushHigh;
         end
         flushHigh:
         begin
            dWEN = 1'b1;
            memSel = dcachePkg::selFlush;
            wordHigh = 1'b1;
            if (!dwait)
            begin
               if (walkLast)
                  nextState = done;
               else
               begin
                  nextWalkPos = walkPos + 1'b1;
                  nextState = flushStep;
               end
            end
         end
         done:
            flushed = 1'b1;   // held until reset
         default:
            nextState = idle;
      endcase
   end

endmodule

/* rtl/dataCache.sv */
`timescale 1ns/100ps

module dataCache (
   input logic CLK,
   input logic nRST,
   input logic dmemREN,
   input logic dmemWEN,
   input dcachePkg::word_t dmemAddr,
   input dcachePkg::word_t dmemStore,
   input logic halt,
   output logic dhit,
   output dcachePkg::word_t dmemLoad,
   output logic flushed,
   output logic dREN,
   output logic dWEN,
   output dcachePkg::word_t daddr,
   output dcachePkg::word_t dstore,
   input dcachePkg::word_t dload,
   input logic dwait
);

   dcachePkg::tag_t reqTag;
   dcachePkg::index_t reqIndex;
   logic reqOffset;
   dcachePkg::lineMeta_t metaA [2];
   dcachePkg::lineMeta_t metaB [2];
   dcachePkg::lineData_t dataA [2];
   dcachePkg::lineData_t dataB [2];
   dcachePkg::lineMeta_t newMeta;
   dcachePkg::lineData_t newData;
   dcachePkg::lineMeta_t victimMeta;
   dcachePkg::lineData_t victimData;
   dcachePkg::lineData_t hitData;
   dcachePkg::index_t flushIndex;
   dcachePkg::memSel_t memSel;
   dcachePkg::word_t hitCount;
   logic [1:0] metaWriteEn;
   logic [1:0] dataWriteEn;
   logic hit;
   logic hitWay;
   logic victimWay;
   logic victimDirty;
   logic flushDirty;
   logic flushWay;
   logic wordHigh;
   logic captureFill;
   logic mergeStore;
   logic markDirty;
   logic lruUpdate;

   assign {reqTag, reqIndex, reqOffset} = dmemAddr[dcachePkg::WORD_WIDTH-1:2];
   assign hitData = dataA[hitWay];
   assign victimDirty = victimMeta.dirty;   // dirty implies valid
   assign flushDirty = metaB[flushWay].dirty;

   for (genvar w = 0; w < 2; w++)
   begin : gWay
      setArray #(.entryT(dcachePkg::lineMeta_t)) metaArray (
         .CLK(CLK), .nRST(nRST), .writeEn(metaWriteEn[w]), .writeIndex(reqIndex),
         .writeEntry(newMeta), .readIndexA(reqIndex), .readEntryA(metaA[w]),
         .readIndexB(flushIndex), .readEntryB(metaB[w]));
      setArray #(.entryT(dcachePkg::lineData_t)) dataArray (
         .CLK(CLK), .nRST(nRST), .writeEn(dataWriteEn[w]), .writeIndex(reqIndex),
         .writeEntry(newData), .readIndexA(reqIndex), .readEntryA(dataA[w]),
         .readIndexB(flushIndex), .readEntryB(dataB[w]));
   end

   wayLookup lookup (
      .CLK(CLK), .nRST(nRST), .reqTag(reqTag), .reqIndex(reqIndex), .wordHigh(reqOffset),
      .meta0(metaA[0]), .meta1(metaA[1]), .data0(dataA[0]), .data1(dataA[1]),
      .lruUpdate(lruUpdate), .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
      .victimMeta(victimMeta), .victimData(victimData), .loadWord(dmemLoad));

   memAccess access (
      .memSel(memSel), .wordHigh(wordHigh), .reqTag(reqTag), .reqIndex(reqIndex),
      .reqOffset(reqOffset), .victimMeta(victimMeta), .victimData(victimData),
      .flushIndex(flushIndex), .flushWay(flushWay), .flushMeta0(metaB[0]),
      .flushMeta1(metaB[1]), .flushData0(dataB[0]), .flushData1(dataB[1]),
      .hitCount(hitCount), .storeWord(dmemStore), .loadWord(dmemLoad), .dload(dload),
      .hitData(hitData), .captureFill(captureFill), .mergeStore(mergeStore),
      .markDirty(markDirty), .daddr(daddr), .dstore(dstore), .newMeta(newMeta),
      .newData(newData));

   cacheController control (
      .CLK(CLK), .nRST(nRST), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
      .dwait(dwait), .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
      .victimDirty(victimDirty), .flushDirty(flushDirty), .dREN(dREN), .dWEN(dWEN),
      .memSel(memSel), .wordHigh(wordHigh), .metaWriteEn(metaWriteEn),
      .dataWriteEn(dataWriteEn), .captureFill(captureFill), .mergeStore(mergeStore),
      .markDirty(markDirty), .lruUpdate(lruUpdate), .flushIndex(flushIndex),
      .flushWay(flushWay), .hitCount(hitCount), .dhit(dhit), .flushed(flushed));

endmodule

/* verification/dataCache_props.sv */
`timescale 1ns/100ps

module dataCache_props (
   input logic CLK,
   input logic nRST,
   input logic dREN,
   input logic dWEN,
   input logic dwait,
   input logic dhit,
   input logic flushed,
   input dcachePkg::memSel_t memSel,
   input logic wordHigh,
   input dcachePkg::index_t flushIndex,
   input logic flushWay
);

   int assertFails = 0;

   oneAccessKind: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN))
   else
   begin
      assertFails++;
      $error("dREN and dWEN high together");
   end

   // address source frozen while memory stalls
   addrHeld: assert property (@(posedge CLK) disable iff (!nRST)
      (dREN || dWEN) && dwait |=> $stable(dREN) && $stable(dWEN) && $stable(memSel)
         && $stable(wordHigh) && $stable(flushIndex) && $stable(flushWay))
   else
   begin
      assertFails++;
      $error("memory access changed while dwait was high");
   end

   noHitWhenFlushed: assert property (@(posedge CLK) disable iff (!nRST) flushed |-> !dhit)
   else
   begin
      assertFails++;
      $error("dhit high while flushed");
   end

endmodule

/* verification/dataCache_tb.sv */
`timescale 1ns/100ps

module dataCache_tb;

   localparam int SEED = 32'h6bb155c3;
   localparam int NUM_REQUESTS = 112;
   localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 40 + 2000;
   localparam dcachePkg::tag_t TAG_BASE = 26'h40;   // lines from 32'h1000

   logic CLK;
   logic nRST;
   logic dmemREN;
   logic dmemWEN;
   logic halt;
   dcachePkg::word_t dmemAddr;
   dcachePkg::word_t dmemStore;
   logic dhit;
   dcachePkg::word_t dmemLoad;
   logic flushed;
   logic dREN;
   logic dWEN;
   dcachePkg::word_t daddr;
   dcachePkg::word_t dstore;
   dcachePkg::word_t dload;
   logic dwait;

   dcachePkg::word_t mem [dcachePkg::word_t];      // memory model
   dcachePkg::word_t shadow [dcachePkg::word_t];   // last stored value per address
   logic valid [dcachePkg::NUM_SETS][2];
   logic dirty [dcachePkg::NUM_SETS][2];
   dcachePkg::tag_t tags [dcachePkg::NUM_SETS][2];
   logic lru [dcachePkg::NUM_SETS];
   dcachePkg::word_t expCount;
   dcachePkg::word_t expLoad;
   dcachePkg::word_t wbQueue [$];   // victim words expected in memory
   int cycleCount = 0;

   dataCache UUT (
      .CLK(CLK), .nRST(nRST), .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemAddr(dmemAddr),
      .dmemStore(dmemStore), .halt(halt), .dhit(dhit), .dmemLoad(dmemLoad),
      .flushed(flushed), .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
      .dload(dload), .dwait(dwait));

   bind cacheController dataCache_props props (
      .CLK(CLK), .nRST(nRST), .dREN(dREN), .dWEN(dWEN), .dwait(dwait), .dhit(dhit),
      .flushed(flushed), .memSel(memSel), .wordHigh(wordHigh), .flushIndex(flushIndex),
      .flushWay(flushWay));

   function automatic dcachePkg::word_t initWord(dcachePkg::word_t addr);
      return ~addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c96_a50f;
   endfunction

   function automatic dcachePkg::word_t memRead(dcachePkg::word_t addr);
      return mem.exists(addr) ? mem[addr] : initWord(addr);
   endfunction

   function automatic dcachePkg::word_t shadowRead(dcachePkg::word_t addr);
      return shadow.exists(addr) ? shadow[addr] : initWord(addr);
   endfunction

   function automatic dcachePkg::word_t makeAddr(int tagNum, int idx, int off);
      return {TAG_BASE + dcachePkg::tag_t'(tagNum), dcachePkg::index_t'(idx), 1'(off), 2'b00};
   endfunction

   // two ways per set, victim named by the lru bit, count on first lookup only
   function automatic dcachePkg::word_t refAccess(logic isWrite, dcachePkg::word_t addr,
                                                  dcachePkg::word_t data);
      dcachePkg::tag_t tag;
      dcachePkg::index_t idx;
      logic found;
      logic way;
      tag = addr[31:6];
      idx = addr[5:3];
      found = 1'b0;
      way = 1'b0;
      for (int w = 0; w < 2; w++)
         if (valid[idx][w] && tags[idx][w] == tag)
         begin
            found = 1'b1;
            way = 1'(w);
         end
      if (found)
         expCount++;
      else
      begin
         way = lru[idx];
         if (dirty[idx][way])
         begin
            wbQueue.push_back({tags[idx][way], idx, 3'b000});
            wbQueue.push_back({tags[idx][way], idx, 3'b100});
         end
         valid[idx][way] = 1'b1;
         dirty[idx][way] = 1'b0;
         tags[idx][way] = tag;
         lru[idx] = !way;   // away from the filled way
      end
      if (isWrite)
      begin
         dirty[idx][way] = 1'b1;
         shadow[addr] = data;
      end
      return shadowRead(addr);
   endfunction

   task automatic failRun(string reason);
      $display("%s", reason);
      $display("STATUS: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkValue(string name, dcachePkg::word_t actual,
                             dcachePkg::word_t expected);
      if (actual !== expected)
         failRun($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
   endtask

   task automatic runRequest(logic isWrite, dcachePkg::word_t addr, dcachePkg::word_t data);
      dcachePkg::word_t wbAddr;
      @(negedge CLK);
      dmemREN = !isWrite;
      dmemWEN = isWrite;
      dmemAddr = addr;
      dmemStore = data;
      expLoad = refAccess(isWrite, addr, data);
      do
         @(posedge CLK);
      while (!dhit);
      while (wbQueue.size() > 0)
      begin
         wbAddr = wbQueue.pop_front();
         checkValue($sformatf("mem[%h]", wbAddr), memRead(wbAddr), shadowRead(wbAddr));
      end
   endtask

   initial
   begin
      CLK = 1'b0;
      forever
         #4 CLK = ~CLK;
   end

   // memory answers one word per low dwait
   initial
   begin
      void'($urandom(SEED));
      dwait = 1'b1;
      dload = '0;
      forever
      begin
         @(negedge CLK);
         dwait = 1'($urandom % 2);
         dload = dREN ? memRead(daddr) : '0;   // read data only on dREN
      end
   end

   always @(posedge CLK)
      if (dWEN && !dwait)
         mem[daddr] = dstore;

   always @(posedge CLK)
      if (dhit && dmemREN)
         checkValue("dmemLoad", dmemLoad, expLoad);

   always @(posedge CLK)
   begin
      cycleCount++;
      if (cycleCount > TIMEOUT_CYCLES)
         failRun($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   initial
   begin
      nRST = 1'b0;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
      dmemAddr = '0;
      dmemStore = '0;
      halt = 1'b0;
      expCount = '0;
      expLoad = '0;
      for (int s = 0; s < dcachePkg::NUM_SETS; s++)
      begin
         lru[s] = 1'b0;
         for (int w = 0; w < 2; w++)
         begin
            valid[s][w] = 1'b0;
            dirty[s][w] = 1'b0;
            tags[s][w] = '0;
         end
      end
      repeat (10) @(negedge CLK);
      nRST = 1'b1;

      for (int s = 0; s < dcachePkg::NUM_SETS; s++)   // both ways of every set
      begin
         for (int t = 0; t < 2; t++)
            for (int o = 0; o < 2; o++)
               runRequest(1'b1, makeAddr(t, s, o), 32'hd000_0000 | (s << 8) | (t << 4) | o);
         for (int t = 0; t < 2; t++)
            for (int o = 0; o < 2; o++)
               runRequest(1'b0, makeAddr(t, s, o), '0);
      end

      for (int s = 0; s < dcachePkg::NUM_SETS; s++)   // third tag evicts
      begin
         runRequest(1'b0, makeAddr(2, s, 0), '0);
         runRequest(1'b0, makeAddr(0, s, 1), '0);
         runRequest(1'b0, makeAddr(1, s, 0), '0);
      end

      for (int s = 0; s < dcachePkg::NUM_SETS; s++)   // write miss keeps fetched word
      begin
         runRequest(1'b1, makeAddr(3, s, s % 2), 32'he000_0000 | s);
         runRequest(1'b0, makeAddr(3, s, (s + 1) % 2), '0);
         runRequest(1'b0, makeAddr(3, s, s % 2), '0);
      end

      @(negedge CLK);
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
      halt = 1'b1;
      do
         @(posedge CLK);
      while (!flushed);
      checkValue("mem[HIT_COUNT_ADDR]", memRead(dcachePkg::HIT_COUNT_ADDR), expCount);
      foreach (shadow[a])
         checkValue($sformatf("mem[%h]", a), memRead(a), shadow[a]);
      @(negedge CLK);
      dmemREN = 1'b1;   // cached line, must get no dhit once flushed
      dmemAddr = makeAddr(3, 0, 0);
      repeat (4)
      begin
         @(posedge CLK);
         checkValue("flushed", flushed, 1);
      end

      if (UUT.control.props.assertFails == 0)
      begin
         $display("STATUS: PASS");
         $finish;
      end
      else
         failRun("a protocol assertion failed during the run");
   end

endmodule

/* dataCache.f */
rtl/dcachePkg.sv
rtl/setArray.sv
rtl/wayLookup.sv
rtl/memAccess.sv
rtl/cacheController.sv
rtl/dataCache.sv
verification/dataCache_props.sv
verification/dataCache_tb.sv

/* Bender.yml */
package:
  name: dataCache

sources:
  - rtl/dcachePkg.sv
  - rtl/setArray.sv
  - rtl/wayLookup.sv
  - rtl/memAccess.sv
  - rtl/cacheController.sv
  - rtl/dataCache.sv
  - target: simulation
    files:
      - verification/dataCache_props.sv
      - verification/dataCache_tb.sv
